// File: common/mem_stage_pkg.sv
package mem_stage_pkg;

  // data and address width
  localparam int xlen = 32;
  // byte lanes per word
  localparam int strb_w = xlen / 8;

  // decoded memory operation from the execute side
  typedef enum logic [3:0] {
    op_none = 4'd0,
    op_lb   = 4'd1,
    op_lbu  = 4'd2,
    op_lh   = 4'd3,
    op_lhu  = 4'd4,
    op_lw   = 4'd5,
    op_sb   = 4'd6,
    op_sh   = 4'd7,
    op_sw   = 4'd8
  } mem_op_e;

  // configuration register byte offsets
  localparam logic [xlen-1:0] reg_base_off  = 32'h0000_0000;
  localparam logic [xlen-1:0] reg_limit_off = 32'h0000_0004;
  localparam logic [xlen-1:0] reg_fault_off = 32'h0000_0008;

  function automatic logic is_load(input mem_op_e op);
    logic result;
    case (op)
      op_lb, op_lbu, op_lh, op_lhu, op_lw: result = 1'b1;
      default: result = 1'b0;
    endcase
    return result;
  endfunction

  function automatic logic is_store(input mem_op_e op);
    logic result;
    case (op)
      op_sb, op_sh, op_sw: result = 1'b1;
      default: result = 1'b0;
    endcase
    return result;
  endfunction

endpackage

// File: accessor/lsu_lanes.sv
`timescale 1ns/1ns

module lsu_lanes (
  input  mem_stage_pkg::mem_op_e            op,
  input  logic [1:0]                        byte_off,
  input  logic [mem_stage_pkg::xlen-1:0]    store_data,
  input  logic [mem_stage_pkg::xlen-1:0]    load_word,
  output logic [mem_stage_pkg::strb_w-1:0]  wstrb,
  output logic [mem_stage_pkg::xlen-1:0]    wdata,
  output logic [mem_stage_pkg::xlen-1:0]    load_result
);
  import mem_stage_pkg::*;

  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  // store side: replicate value, strobe picks the lanes
  always_comb begin
    wstrb = '0;
    wdata = store_data;
    if (is_store(op)) begin
      case (op)
        op_sb: begin
          wstrb = 4'b0001 << byte_off;
          wdata = {4{store_data[7:0]}};
        end
        op_sh: begin
          wstrb = byte_off[1] ? 4'b1100 : 4'b0011;
          wdata = {2{store_data[15:0]}};
        end
        default: begin
          wstrb = '1;
        end
      endcase
    end
  end

  // addressed byte and halfword of the returned word
  always_comb begin
    case (byte_off)
      2'b00: sel_byte = load_word[7:0];
      2'b01: sel_byte = load_word[15:8];
      2'b10: sel_byte = load_word[23:16];
      default: sel_byte = load_word[31:24];
    endcase
    sel_half = byte_off[1] ? load_word[31:16] : load_word[15:0];
  end

  // extend by operation, zero for anything that is not a load
  always_comb begin
    load_result = '0;
    if (is_load(op)) begin
      case (op)
        op_lb:  load_result = {{(xlen-8){sel_byte[7]}}, sel_byte};
        op_lbu: load_result = {{(xlen-8){1'b0}}, sel_byte};
        op_lh:  load_result = {{(xlen-16){sel_half[15]}}, sel_half};
        op_lhu: load_result = {{(xlen-16){1'b0}}, sel_half};
        default: load_result = load_word;
      endcase
    end
  end

endmodule

// File: accessor/lsu_ctrl.sv
`timescale 1ns/1ns

module lsu_ctrl (
  input  logic                              clk,
  input  logic                              reset,
  // request from execute
  input  logic                              req_valid,
  output logic                              req_ready,
  input  mem_stage_pkg::mem_op_e            req_op,
  input  logic [mem_stage_pkg::xlen-1:0]    req_addr,
  input  logic [mem_stage_pkg::xlen-1:0]    req_wdata,
  input  logic [4:0]                        req_rd,
  // result to writeback
  output logic                              rsp_valid,
  input  logic                              rsp_ready,
  output logic [mem_stage_pkg::xlen-1:0]    rsp_data,
  output logic [4:0]                        rsp_rd,
  output logic                              rsp_fault,
  // access window and fault reporting
  input  logic [mem_stage_pkg::xlen-1:0]    win_base,
  input  logic [mem_stage_pkg::xlen-1:0]    win_limit,
  output logic                              fault_pulse,
  // data APB master
  output logic [mem_stage_pkg::xlen-1:0]    paddr,
  output logic                              psel,
  output logic                              penable,
  output logic                              pwrite,
  output logic [mem_stage_pkg::xlen-1:0]    pwdata,
  output logic [mem_stage_pkg::strb_w-1:0]  pstrb,
  input  logic [mem_stage_pkg::xlen-1:0]    prdata,
  input  logic                              pready
);
  import mem_stage_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_access,
    st_respond
  } state_e;

  state_e            state;
  mem_op_e           op_q;
  logic [xlen-3:0]   word_addr_q;
  logic [1:0]        off_q;
  logic [xlen-1:0]   wdata_q;
  logic [xlen-1:0]   load_result;
  logic              accept;
  logic              is_mem;
  logic              misaligned;
  logic              outside;
  logic              fault;

  assign req_ready = (state == st_idle);
  assign accept    = req_valid && req_ready;
  assign rsp_valid = (state == st_respond);

  // window and alignment check on the incoming request
  always_comb begin
    case (req_op)
      op_lh, op_lhu, op_sh: misaligned = req_addr[0];
      op_lw, op_sw:         misaligned = |req_addr[1:0];
      default:              misaligned = 1'b0;
    endcase
    outside = (req_addr < win_base) || (req_addr > win_limit);
    is_mem  = is_load(req_op) || is_store(req_op);
    fault   = is_mem && (misaligned || outside);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= st_idle;
      fault_pulse <= 1'b0;
    end else begin
      fault_pulse <= 1'b0;
      case (state)
        st_idle: begin
          if (accept) begin
            // faults and no-op requests skip the bus
            if (fault) begin
              fault_pulse <= 1'b1;
              state       <= st_respond;
            end else if (!is_mem) begin
              state <= st_respond;
            end else begin
              state <= st_setup;
            end
          end
        end
        st_setup: state <= st_access;
        st_access: begin
          if (pready) begin
            state <= st_respond;
          end
        end
        default: begin
          if (rsp_ready) begin
            state <= st_idle;
          end
        end
      endcase
    end
  end

  // request and result payload
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q        <= req_op;
      word_addr_q <= req_addr[xlen-1:2];
      off_q       <= req_addr[1:0];
      wdata_q     <= req_wdata;
      rsp_rd      <= req_rd;
      rsp_fault   <= fault;
      rsp_data    <= '0;
    end else if (state == st_access && pready) begin
      rsp_data <= load_result;
    end
  end

  lsu_lanes u_lanes (
    .op          (op_q),
    .byte_off    (off_q),
    .store_data  (wdata_q),
    .load_word   (prdata),
    .wstrb       (pstrb),
    .wdata       (pwdata),
    .load_result (load_result)
  );

  // APB master outputs follow the state
  assign psel    = (state == st_setup) || (state == st_access);
  assign penable = (state == st_access);
  assign paddr   = {word_addr_q, 2'b00};
  assign pwrite  = is_store(op_q);

endmodule

// File: rtl/mem_window_regs.sv
`timescale 1ns/1ns

module mem_window_regs #(
  parameter int ram_words = 256
) (
  input  logic                            clk,
  input  logic                            reset,
  // configuration APB slave
  input  logic [mem_stage_pkg::xlen-1:0]  cfg_paddr,
  input  logic                            cfg_psel,
  input  logic                            cfg_penable,
  input  logic                            cfg_pwrite,
  input  logic [mem_stage_pkg::xlen-1:0]  cfg_pwdata,
  output logic [mem_stage_pkg::xlen-1:0]  cfg_prdata,
  output logic                            cfg_pready,
  // from the access stage
  input  logic                            fault_pulse,
  // window to the access stage
  output logic [mem_stage_pkg::xlen-1:0]  win_base,
  output logic [mem_stage_pkg::xlen-1:0]  win_limit
);
  import mem_stage_pkg::*;

  // last byte address of the data RAM
  localparam logic [xlen-1:0] limit_rst = xlen'(ram_words * 4 - 1);

  logic [15:0] fault_count;
  logic        wr_en;

  // zero wait states
  assign cfg_pready = 1'b1;
  assign wr_en      = cfg_psel && cfg_penable && cfg_pwrite;

  always_ff @(posedge clk) begin
    if (reset) begin
      win_base    <= '0;
      win_limit   <= limit_rst;
      fault_count <= '0;
    end else begin
      if (wr_en && cfg_paddr == reg_base_off) begin
        win_base <= cfg_pwdata;
      end
      if (wr_en && cfg_paddr == reg_limit_off) begin
        win_limit <= cfg_pwdata;
      end
      // a write clears, otherwise count up and stick at all ones
      if (wr_en && cfg_paddr == reg_fault_off) begin
        fault_count <= '0;
      end else if (fault_pulse && fault_count != '1) begin
        fault_count <= fault_count + 16'd1;
      end
    end
  end

  // read mux, unmapped offsets return zero
  always_comb begin
    case (cfg_paddr)
      reg_base_off:  cfg_prdata = win_base;
      reg_limit_off: cfg_prdata = win_limit;
      reg_fault_off: cfg_prdata = {{(xlen-16){1'b0}}, fault_count};
      default:       cfg_prdata = '0;
    endcase
  end

endmodule

// File: rtl/apb_data_ram.sv
`timescale 1ns/1ns

module apb_data_ram #(
  parameter int ram_words = 256,
  parameter int ram_wait  = 1
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [mem_stage_pkg::xlen-1:0]    paddr,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [mem_stage_pkg::xlen-1:0]    pwdata,
  input  logic [mem_stage_pkg::strb_w-1:0]  pstrb,
  output logic [mem_stage_pkg::xlen-1:0]    prdata,
  output logic                              pready
);
  import mem_stage_pkg::*;

  localparam int idx_w = (ram_words > 1) ? $clog2(ram_words) : 1;
  localparam int cnt_w = (ram_wait > 0) ? $clog2(ram_wait + 1) : 1;

  logic [xlen-1:0]  mem [ram_words];
  logic [xlen-3:0]  word_addr;
  logic [idx_w-1:0] idx;
  logic [cnt_w-1:0] wait_cnt;
  logic             access;

  // word index, wrapping past the end of the array
  assign word_addr = paddr[xlen-1:2];
  assign idx       = idx_w'(word_addr % ram_words);
  assign access    = psel && penable;
  assign pready    = access && (wait_cnt == cnt_w'(ram_wait));
  assign prdata    = mem[idx];

  // wait states counted inside the access phase
  always_ff @(posedge clk) begin
    if (reset) begin
      wait_cnt <= '0;
    end else if (access && pready) begin
      wait_cnt <= '0;
    end else if (access) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // only strobed lanes are written
  always_ff @(posedge clk) begin
    if (access && pready && pwrite) begin
      for (int i = 0; i < strb_w; i++) begin
        if (pstrb[i]) begin
          mem[idx][8*i +: 8] <= pwdata[8*i +: 8];
        end
      end
    end
  end

endmodule

// File: rtl/mem_stage_top.sv
`timescale 1ns/1ns

module mem_stage_top #(
  parameter int ram_words = 256,
  parameter int ram_wait  = 1
) (
  input  logic                            clk,
  input  logic                            reset,
  // request port
  input  logic                            req_valid,
  output logic                            req_ready,
  input  mem_stage_pkg::mem_op_e          req_op,
  input  logic [mem_stage_pkg::xlen-1:0]  req_addr,
  input  logic [mem_stage_pkg::xlen-1:0]  req_wdata,
  input  logic [4:0]                      req_rd,
  // result port
  output logic                            rsp_valid,
  input  logic                            rsp_ready,
  output logic [mem_stage_pkg::xlen-1:0]  rsp_data,
  output logic [4:0]                      rsp_rd,
  output logic                            rsp_fault,
  // configuration APB slave
  input  logic [mem_stage_pkg::xlen-1:0]  cfg_paddr,
  input  logic                            cfg_psel,
  input  logic                            cfg_penable,
  input  logic                            cfg_pwrite,
  input  logic [mem_stage_pkg::xlen-1:0]  cfg_pwdata,
  output logic [mem_stage_pkg::xlen-1:0]  cfg_prdata,
  output logic                            cfg_pready
);
  import mem_stage_pkg::*;

  logic [xlen-1:0]   win_base;
  logic [xlen-1:0]   win_limit;
  logic              fault_pulse;
  // data bus between the stage and the RAM
  logic [xlen-1:0]   paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [xlen-1:0]   pwdata;
  logic [strb_w-1:0] pstrb;
  logic [xlen-1:0]   prdata;
  logic              pready;

  lsu_ctrl u_lsu_ctrl (
    .clk         (clk),
    .reset       (reset),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .req_op      (req_op),
    .req_addr    (req_addr),
    .req_wdata   (req_wdata),
    .req_rd      (req_rd),
    .rsp_valid   (rsp_valid),
    .rsp_ready   (rsp_ready),
    .rsp_data    (rsp_data),
    .rsp_rd      (rsp_rd),
    .rsp_fault   (rsp_fault),
    .win_base    (win_base),
    .win_limit   (win_limit),
    .fault_pulse (fault_pulse),
    .paddr       (paddr),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .pwdata      (pwdata),
    .pstrb       (pstrb),
    .prdata      (prdata),
    .pready      (pready)
  );

  apb_data_ram #(
    .ram_words (ram_words),
    .ram_wait  (ram_wait)
  ) u_ram (
    .clk     (clk),
    .reset   (reset),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .prdata  (prdata),
    .pready  (pready)
  );

  mem_window_regs #(
    .ram_words (ram_words)
  ) u_window_regs (
    .clk         (clk),
    .reset       (reset),
    .cfg_paddr   (cfg_paddr),
    .cfg_psel    (cfg_psel),
    .cfg_penable (cfg_penable),
    .cfg_pwrite  (cfg_pwrite),
    .cfg_pwdata  (cfg_pwdata),
    .cfg_prdata  (cfg_prdata),
    .cfg_pready  (cfg_pready),
    .fault_pulse (fault_pulse),
    .win_base    (win_base),
    .win_limit   (win_limit)
  );

endmodule

// File: sim/mem_stage_asserts.sv
`timescale 1ns/1ns

module mem_stage_asserts (
  input logic                              clk,
  input logic                              reset,
  input logic                              psel,
  input logic                              penable,
  input logic                              pwrite,
  input logic [mem_stage_pkg::xlen-1:0]    paddr,
  input logic [mem_stage_pkg::xlen-1:0]    pwdata,
  input logic [mem_stage_pkg::strb_w-1:0]  pstrb,
  input logic                              pready,
  input logic                              req_ready,
  input logic                              rsp_valid,
  input logic                              rsp_ready,
  input logic [mem_stage_pkg::xlen-1:0]    rsp_data,
  input logic [4:0]                        rsp_rd,
  input logic                              rsp_fault
);
  int assert_failures = 0;

  // access phase only right after a setup cycle
  assert property (@(posedge clk) disable iff (reset)
    $rose(penable) |-> $past(psel && !penable))
    else begin
      assert_failures++;
      $error("penable rose without a setup cycle");
    end

  // bus held while the RAM inserts wait states
  assert property (@(posedge clk) disable iff (reset)
    (psel && penable && !pready) |=> (psel && penable && $stable(paddr) &&
      $stable(pwrite) && $stable(pwdata) && $stable(pstrb)))
    else begin
      assert_failures++;
      $error("APB signals changed while waiting for pready");
    end

  assert property (@(posedge clk) disable iff (reset)
    (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_data) &&
      $stable(rsp_rd) && $stable(rsp_fault)))
    else begin
      assert_failures++;
      $error("result changed while stalled by writeback");
    end

  assert property (@(posedge clk) disable iff (reset) rsp_valid |-> !req_ready)
    else begin
      assert_failures++;
      $error("req_ready high while a result is pending");
    end

endmodule

// File: sim/tb_mem_stage.sv
`timescale 1ns/1ns

module tb_mem_stage;
  import mem_stage_pkg::*;

  localparam int ram_words    = 256;
  localparam int ram_wait     = 2;
  localparam int reset_cycles = 10;
  // data requests plus config transfers over all tests, rounded up
  localparam int planned_requests = 560;
  localparam int timeout_cycles   = reset_cycles + 40 * planned_requests;

  logic              clk;
  logic              reset;
  logic              req_valid;
  logic              req_ready;
  mem_op_e           req_op;
  logic [xlen-1:0]   req_addr;
  logic [xlen-1:0]   req_wdata;
  logic [4:0]        req_rd;
  logic              rsp_valid;
  logic              rsp_ready;
  logic [xlen-1:0]   rsp_data;
  logic [4:0]        rsp_rd;
  logic              rsp_fault;
  logic [xlen-1:0]   cfg_paddr;
  logic              cfg_psel;
  logic              cfg_penable;
  logic              cfg_pwrite;
  logic [xlen-1:0]   cfg_pwdata;
  logic [xlen-1:0]   cfg_prdata;
  logic              cfg_pready;

  // byte-wide reference memory and window copy
  logic [7:0]        ref_mem [ram_words*4];
  logic [xlen-1:0]   cur_base;
  logic [xlen-1:0]   cur_limit;
  logic [4:0]        next_rd;
  mem_op_e           op_list [8] = '{op_lb, op_lbu, op_lh, op_lhu, op_lw, op_sb, op_sh, op_sw};
  integer            seed;
  int                checks;
  int                word_errors;
  int                fault_errors;
  int                rd_errors;
  int                other_errors;
  int                faults_seen;
  int                cycle_count = 0;

  mem_stage_top #(
    .ram_words (ram_words),
    .ram_wait  (ram_wait)
  ) u_dut (
    .clk         (clk),
    .reset       (reset),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .req_op      (req_op),
    .req_addr    (req_addr),
    .req_wdata   (req_wdata),
    .req_rd      (req_rd),
    .rsp_valid   (rsp_valid),
    .rsp_ready   (rsp_ready),
    .rsp_data    (rsp_data),
    .rsp_rd      (rsp_rd),
    .rsp_fault   (rsp_fault),
    .cfg_paddr   (cfg_paddr),
    .cfg_psel    (cfg_psel),
    .cfg_penable (cfg_penable),
    .cfg_pwrite  (cfg_pwrite),
    .cfg_pwdata  (cfg_pwdata),
    .cfg_prdata  (cfg_prdata),
    .cfg_pready  (cfg_pready)
  );

  bind lsu_ctrl mem_stage_asserts u_asserts (
    .clk       (clk),
    .reset     (reset),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .pstrb     (pstrb),
    .pready    (pready),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_data  (rsp_data),
    .rsp_rd    (rsp_rd),
    .rsp_fault (rsp_fault)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic check_word(input string name, input logic [xlen-1:0] got,
                            input logic [xlen-1:0] exp);
    checks++;
    if (got !== exp) begin
      word_errors++;
      $display("FAIL %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_fault(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      fault_errors++;
      $display("FAIL %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_rd(input string name, input logic [4:0] got, input logic [4:0] exp);
    checks++;
    if (got !== exp) begin
      rd_errors++;
      $display("FAIL %s: got %h, expected %h", name, got, exp);
    end
  endtask

  function automatic int op_size(input mem_op_e op);
    case (op)
      op_lb, op_lbu, op_sb: return 1;
      op_lh, op_lhu, op_sh: return 2;
      op_lw, op_sw:         return 4;
      default:              return 0;
    endcase
  endfunction

  function automatic logic op_writes(input mem_op_e op);
    return op inside {op_sb, op_sh, op_sw};
  endfunction

  // natural alignment, then the start address against the window
  function automatic logic expect_fault(input mem_op_e op, input logic [xlen-1:0] addr);
    int size;
    size = op_size(op);
    if (size == 0) begin
      return 1'b0;
    end
    if (addr % size != 0) begin
      return 1'b1;
    end
    return (addr < cur_base) || (addr > cur_limit);
  endfunction

  function automatic logic [xlen-1:0] expect_load(input mem_op_e op, input logic [xlen-1:0] addr);
    int         a;
    logic [7:0] b;
    logic [15:0] h;
    a = int'(addr);
    b = ref_mem[a];
    case (op)
      op_lb:  return {{24{b[7]}}, b};
      op_lbu: return {24'h0, b};
      op_lh: begin
        h = {ref_mem[a+1], ref_mem[a]};
        return {{16{h[15]}}, h};
      end
      op_lhu: begin
        h = {ref_mem[a+1], ref_mem[a]};
        return {16'h0, h};
      end
      default: return {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
    endcase
  endfunction

  // little-endian byte placement
  task automatic store_ref(input mem_op_e op, input logic [xlen-1:0] addr,
                           input logic [xlen-1:0] wdata);
    for (int i = 0; i < op_size(op); i++) begin
      ref_mem[int'(addr) + i] = wdata[8*i +: 8];
    end
  endtask

  // one request, result held for stall cycles before rsp_ready
  task automatic run_request(input mem_op_e op, input logic [xlen-1:0] addr,
                             input logic [xlen-1:0] wdata, input logic [4:0] rd,
                             input int stall, output logic [xlen-1:0] data,
                             output logic fault, output logic [4:0] rd_out);
    logic [xlen-1:0] held;
    @(posedge clk);
    req_valid <= 1'b1;
    req_op    <= op;
    req_addr  <= addr;
    req_wdata <= wdata;
    req_rd    <= rd;
    rsp_ready <= (stall == 0);
    do @(posedge clk); while (!req_ready);
    req_valid <= 1'b0;
    if (stall > 0) begin
      do @(posedge clk); while (!rsp_valid);
      held = rsp_data;
      for (int i = 0; i < stall; i++) begin
        @(posedge clk);
        if (req_ready) begin
          other_errors++;
          $display("request port was ready while a result was still held");
        end
        check_word("rsp_data held", rsp_data, held);
      end
      rsp_ready <= 1'b1;
    end
    do @(posedge clk); while (!(rsp_valid && rsp_ready));
    data   = rsp_data;
    fault  = rsp_fault;
    rd_out = rsp_rd;
  endtask

  task automatic issue_access(input mem_op_e op, input logic [xlen-1:0] addr,
                              input logic [xlen-1:0] wdata, input int stall);
    logic [xlen-1:0] data;
    logic            fault;
    logic [4:0]      rd;
    logic [4:0]      rd_out;
    logic            exp_fault;
    rd        = next_rd;
    next_rd   = next_rd + 5'd1;
    exp_fault = expect_fault(op, addr);
    run_request(op, addr, wdata, rd, stall, data, fault, rd_out);
    check_rd("rsp_rd", rd_out, rd);
    check_fault("rsp_fault", fault, exp_fault);
    if (exp_fault) begin
      faults_seen++;
      check_word("rsp_data", data, '0);
    end else if (op_writes(op)) begin
      store_ref(op, addr, wdata);
    end else begin
      check_word("rsp_data", data, expect_load(op, addr));
    end
  endtask

  task automatic cfg_write(input logic [xlen-1:0] addr, input logic [xlen-1:0] data);
    @(posedge clk);
    cfg_psel    <= 1'b1;
    cfg_penable <= 1'b0;
    cfg_pwrite  <= 1'b1;
    cfg_paddr   <= addr;
    cfg_pwdata  <= data;
    @(posedge clk);
    cfg_penable <= 1'b1;
    do @(posedge clk); while (!cfg_pready);
    cfg_psel    <= 1'b0;
    cfg_penable <= 1'b0;
    if (addr == reg_base_off) begin
      cur_base = data;
    end else if (addr == reg_limit_off) begin
      cur_limit = data;
    end
  endtask

  task automatic cfg_read(input logic [xlen-1:0] addr, output logic [xlen-1:0] data);
    @(posedge clk);
    cfg_psel    <= 1'b1;
    cfg_penable <= 1'b0;
    cfg_pwrite  <= 1'b0;
    cfg_paddr   <= addr;
    @(posedge clk);
    cfg_penable <= 1'b1;
    do @(posedge clk); while (!cfg_pready);
    data = cfg_prdata;
    cfg_psel    <= 1'b0;
    cfg_penable <= 1'b0;
  endtask

  task automatic set_window(input logic [xlen-1:0] base, input logic [xlen-1:0] limit);
    cfg_write(reg_base_off, base);
    cfg_write(reg_limit_off, limit);
  endtask

  task automatic test_config_readback();
    logic [xlen-1:0] data;
    cfg_read(reg_base_off, data);
    check_word("win_base", data, '0);
    cfg_read(reg_limit_off, data);
    check_word("win_limit", data, xlen'(ram_words * 4 - 1));
    cfg_read(reg_fault_off, data);
    check_word("fault_count", data, '0);
    set_window(32'h0000_0140, 32'h0000_02bf);
    cfg_read(reg_base_off, data);
    check_word("win_base", data, 32'h0000_0140);
    cfg_read(reg_limit_off, data);
    check_word("win_limit", data, 32'h0000_02bf);
    cfg_read(32'h0000_000c, data);
    check_word("unmapped", data, '0);
    set_window('0, xlen'(ram_words * 4 - 1));
  endtask

  // every word gets a value built from its full address
  task automatic fill_memory();
    logic [xlen-1:0] a;
    for (int w = 0; w < ram_words; w++) begin
      a = xlen'(w * 4);
      issue_access(op_sw, a, {a[15:0] ^ 16'hc35a, ~a[15:0]}, 0);
    end
  endtask

  task automatic test_word_access();
    logic [xlen-1:0] addr;
    for (int i = 0; i < 6; i++) begin
      if (i == 0) begin
        addr = '0;
      end else if (i == 1) begin
        addr = xlen'(ram_words * 4 - 4);
      end else begin
        addr = xlen'({$random(seed)} % ram_words) * 4;
      end
      issue_access(op_sw, addr, $random(seed), 0);
      issue_access(op_lw, addr, '0, 0);
    end
  endtask

  task automatic test_sub_word();
    logic [xlen-1:0] base;
    base = 32'h0000_0120;
    for (int off = 0; off < 4; off++) begin
      issue_access(op_sb, base + off, $random(seed), 0);
      issue_access(op_lw, base, '0, 0);
    end
    for (int off = 0; off < 4; off += 2) begin
      issue_access(op_sh, base + off, $random(seed), 0);
      issue_access(op_lw, base, '0, 0);
    end
    // both signs in bytes and halfwords
    issue_access(op_sw, base, 32'h80f1_7f85, 0);
    for (int off = 0; off < 4; off++) begin
      issue_access(op_lb, base + off, '0, 0);
      issue_access(op_lbu, base + off, '0, 0);
    end
    for (int off = 0; off < 4; off += 2) begin
      issue_access(op_lh, base + off, '0, 0);
      issue_access(op_lhu, base + off, '0, 0);
    end
  endtask

  task automatic test_faults();
    logic [xlen-1:0] data;
    cfg_write(reg_fault_off, '0);
    faults_seen = 0;
    issue_access(op_lh, 32'h0000_0201, '0, 0);
    issue_access(op_lw, 32'h0000_0202, '0, 0);
    issue_access(op_lhu, 32'h0000_0203, '0, 0);
    issue_access(op_sw, 32'h0000_0206, 32'h1234_5678, 0);
    set_window(32'h0000_0100, 32'h0000_01ff);
    issue_access(op_lw, 32'h0000_00fc, '0, 0);
    issue_access(op_lb, 32'h0000_0200, '0, 0);
    issue_access(op_lw, 32'h0000_0100, '0, 0);
    issue_access(op_lbu, 32'h0000_01ff, '0, 0);
    issue_access(op_sw, 32'h0000_0040, 32'hdead_beef, 0);
    issue_access(op_sb, 32'h0000_03f0, 32'h0000_00a5, 0);
    set_window('0, xlen'(ram_words * 4 - 1));
    // blocked stores left the RAM alone
    issue_access(op_lw, 32'h0000_0040, '0, 0);
    issue_access(op_lw, 32'h0000_03f0, '0, 0);
    cfg_read(reg_fault_off, data);
    check_word("fault_count", data, xlen'(faults_seen));
    cfg_write(reg_fault_off, 32'h0000_1234);
    faults_seen = 0;
    cfg_read(reg_fault_off, data);
    check_word("fault_count", data, '0);
  endtask

  task automatic test_back_pressure();
    logic [xlen-1:0] addr;
    for (int i = 0; i < 4; i++) begin
      addr = xlen'({$random(seed)} % ram_words) * 4;
      issue_access(op_sw, addr, $random(seed), 1 + {$random(seed)} % 12);
      issue_access(op_lw, addr, '0, 1 + {$random(seed)} % 12);
    end
    issue_access(op_lw, 32'h0000_0011, '0, 5);
  endtask

  task automatic test_random();
    mem_op_e         op;
    logic [xlen-1:0] addr;
    set_window(32'h0000_0080, 32'h0000_037f);
    repeat (200) begin
      op   = op_list[{$random(seed)} % 8];
      addr = xlen'({$random(seed)} % 1100);
      // half the requests naturally aligned
      if ($random(seed) & 1) begin
        addr = addr & ~xlen'(op_size(op) - 1);
      end
      issue_access(op, addr, $random(seed), 0);
    end
    set_window('0, xlen'(ram_words * 4 - 1));
  endtask

  initial begin
    int assert_errors;
    int total;
    seed         = 32'hce847c4d;
    checks       = 0;
    word_errors  = 0;
    fault_errors = 0;
    rd_errors    = 0;
    other_errors = 0;
    faults_seen  = 0;
    next_rd      = 5'd1;
    cur_base     = '0;
    cur_limit    = xlen'(ram_words * 4 - 1);
    reset        = 1'b1;
    req_valid    = 1'b0;
    req_op       = op_none;
    req_addr     = '0;
    req_wdata    = '0;
    req_rd       = '0;
    rsp_ready    = 1'b0;
    cfg_paddr    = '0;
    cfg_psel     = 1'b0;
    cfg_penable  = 1'b0;
    cfg_pwrite   = 1'b0;
    cfg_pwdata   = '0;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;

    test_config_readback();
    fill_memory();
    test_word_access();
    test_sub_word();
    test_faults();
    test_back_pressure();
    test_random();
    repeat (5) @(posedge clk);

    assert_errors = u_dut.u_lsu_ctrl.u_asserts.assert_failures;
    total = word_errors + fault_errors + rd_errors + other_errors + assert_errors;
    $display("checks %0d, word errors %0d, fault errors %0d, rd errors %0d, other %0d, asserts %0d",
             checks, word_errors, fault_errors, rd_errors, other_errors, assert_errors);
    if (total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: sources.f
common/mem_stage_pkg.sv
accessor/lsu_lanes.sv
accessor/lsu_ctrl.sv
rtl/mem_window_regs.sv
rtl/apb_data_ram.sv
rtl/mem_stage_top.sv
sim/mem_stage_asserts.sv
sim/tb_mem_stage.sv

// File: Bender.yml
package:
  name: mem_stage

sources:
  # shared package first
  - common/mem_stage_pkg.sv
  # access stage
  - accessor/lsu_lanes.sv
  - accessor/lsu_ctrl.sv
  # memory side and top level
  - rtl/mem_window_regs.sv
  - rtl/apb_data_ram.sv
  - rtl/mem_stage_top.sv
  # testbench
  - target: simulation
    files:
      - sim/mem_stage_asserts.sv
      - sim/tb_mem_stage.sv
